// ==== compile.f ====
+incdir+common
common/audio_pkg.sv
source/i2s_receiver.sv
filter/smoothing_filter.sv
source/i2s_transmitter.sv
source/audio_smoother_top.sv
tests/audio_smoother_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the audio smoother testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
  -f compile.f --top-module audio_smoother_tb -o audio_smoother_sim

./obj_dir/audio_smoother_sim | tee sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
  exit 1
fi
exit 0

// ==== tests/audio_smoother_tb.sv ====
`timescale 1ns/1ps
`include "audio_cfg.svh"

module audio_smoother_tb;

  import audio_pkg::*;

  localparam int      BCLK_HALF    = 8;  // clk periods per bclk half period
  localparam int      FRAME_NS     = 2 * `SLOT_W * 2 * BCLK_HALF * 40;
  localparam int      AVG_CLEAR    = 16;
  localparam int      AVG_RUN      = 20;
  localparam int      TOTAL_FRAMES = 2 + 12 + 4 * (AVG_CLEAR + AVG_RUN) + 24 + 24 + 16 + 1;
  localparam int      WATCHDOG_NS  = TOTAL_FRAMES * FRAME_NS * 3 / 2;
  localparam sample_t FULL_NEG     = 24'sh800000;
  localparam filt_mode_e AVG_MODES [4] = '{FILT_AVG2, FILT_AVG4, FILT_AVG8, FILT_AVG16};

  logic          clk;
  logic          reset_n;
  logic          bclk;
  logic          lrclk;
  logic          sdata_in;
  filt_mode_e    filt_mode;
  logic          sdata_out;

  logic [31:0]   lfsr_state;
  sample_t       model_taps [2][`DELAY_DEPTH];  // Left and right history
  stereo_frame_u exp_q [$];
  stereo_frame_u rx_q [$];
  logic          idle_check;
  int            error_count;
  int            tests_passed;
  int            tests_failed;
  int            mon_pos = -1;
  logic          mon_lr = 1'b0;
  stereo_frame_u mon_shift;

  audio_smoother_top audio_smoother_top_inst (
    .clk       (clk),
    .reset_n   (reset_n),
    .bclk      (bclk),
    .lrclk     (lrclk),
    .sdata_in  (sdata_in),
    .filt_mode (filt_mode),
    .sdata_out (sdata_out)
  );

  always #20 clk = ~clk;

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic lfsr_bit();
    logic fb;
    fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  function automatic sample_t random_sample();
    sample_t s;
    s = '0;
    for (int i = 0; i < `SAMPLE_W; i++) begin
      s = {s[`SAMPLE_W-2:0], lfsr_bit()};
    end
    return s;
  endfunction

  // Division by 2^shift, rounding toward minus infinity
  function automatic longint floor_div_pow2(input longint num, input int shift);
    longint den;
    longint quot;
    den  = longint'(1) << shift;
    quot = num / den;
    if (num < 0 && quot * den != num) quot = quot - 1;
    return quot;
  endfunction

  function automatic sample_t model_output(input int ch, input filt_mode_e mode);
    longint acc;
    int     avg_shift;
    acc = 0;
    case (mode)
      FILT_AVG2:  avg_shift = 1;
      FILT_AVG4:  avg_shift = 2;
      FILT_AVG8:  avg_shift = 3;
      FILT_AVG16: avg_shift = 4;
      default:    avg_shift = 0;
    endcase
    if (avg_shift > 0) begin
      for (int i = 0; i < (1 << avg_shift); i++) begin
        acc = acc + longint'(model_taps[ch][i]);
      end
      acc = floor_div_pow2(acc, avg_shift);
    end else if (mode == FILT_WGT_HALF || mode == FILT_WGT_UNITY) begin
      acc = floor_div_pow2(longint'(model_taps[ch][0]), 4)
          + floor_div_pow2(longint'(model_taps[ch][1]), 4)
          + floor_div_pow2(longint'(model_taps[ch][2]), 3)
          + floor_div_pow2(longint'(model_taps[ch][3]), 2);
      if (mode == FILT_WGT_UNITY) acc = acc + floor_div_pow2(longint'(model_taps[ch][4]), 1);
    end else begin
      acc = longint'(model_taps[ch][0]);  // Modes 0 and 7
    end
    return sample_t'(acc);
  endfunction

  task automatic check_sample(input string name, input sample_t expected, input sample_t actual);
    if (actual !== expected) begin
      $display("ERROR %s expected %06h actual %06h", name, expected, actual);
      error_count++;
    end
  endtask

  task automatic check_idle_bit(input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("ERROR sdata_out expected %0h actual %0h", expected, actual);
      error_count++;
    end
  endtask

  task automatic send_frame(input sample_t left, input sample_t right);
    stereo_frame_u frame;
    stereo_frame_u expected;
    int            bit_idx;
    frame.ch.left  = left;
    frame.ch.right = right;
    // This period carries the previous frame, filtered in the mode set now
    expected.ch.left  = model_output(0, filt_mode);
    expected.ch.right = model_output(1, filt_mode);
    exp_q.push_back(expected);
    for (int i = `DELAY_DEPTH - 1; i > 0; i--) begin
      model_taps[0][i] = model_taps[0][i-1];
      model_taps[1][i] = model_taps[1][i-1];
    end
    model_taps[0][0] = left;
    model_taps[1][0] = right;
    for (int slot = 0; slot < 2; slot++) begin
      for (int pos = 0; pos < `SLOT_W; pos++) begin
        bit_idx  = (2 - slot) * `SAMPLE_W - pos;
        bclk     = 1'b0;
        lrclk    = (slot == 1);
        sdata_in = (pos >= 1 && pos <= `SAMPLE_W) ? frame.raw[bit_idx] : 1'b0;
        repeat (BCLK_HALF) @(negedge clk);
        bclk = 1'b1;
        repeat (BCLK_HALF) @(negedge clk);
      end
    end
  endtask

  // Output deserializer, one frame per lrclk period
  always @(posedge bclk) begin
    if (lrclk != mon_lr) mon_pos = 0;
    else mon_pos = mon_pos + 1;
    mon_lr = lrclk;
    if (idle_check) check_idle_bit(1'b0, sdata_out);
    if (mon_pos >= 1 && mon_pos <= `SAMPLE_W) begin
      mon_shift.raw = {mon_shift.raw[2*`SAMPLE_W-2:0], sdata_out};
    end
    if (lrclk && mon_pos == `SAMPLE_W) rx_q.push_back(mon_shift);
  end

  task automatic compare_frames();
    stereo_frame_u want;
    stereo_frame_u got;
    if (exp_q.size() != rx_q.size()) begin
      $display("Monitor holds %0d frames from sdata_out where %0d were due",
               rx_q.size(), exp_q.size());
      error_count++;
    end
    while (exp_q.size() > 0 && rx_q.size() > 0) begin
      want = exp_q.pop_front();
      got  = rx_q.pop_front();
      check_sample("sdata_out left", want.ch.left, got.ch.left);
      check_sample("sdata_out right", want.ch.right, got.ch.right);
    end
  endtask

  task automatic finish_test(input string name, input int errors_before);
    if (error_count == errors_before) begin
      tests_passed++;
      $display("Test %s passed", name);
    end else begin
      tests_failed++;
      $display("Test %s failed with %0d errors", name, error_count - errors_before);
    end
  endtask

  task automatic test_reset();
    int errors_before;
    errors_before = error_count;
    idle_check    = 1'b1;
    send_frame('0, '0);
    send_frame('0, '0);
    idle_check = 1'b0;
    compare_frames();
    finish_test("reset", errors_before);
  endtask

  task automatic test_bypass();
    int errors_before;
    errors_before = error_count;
    filt_mode     = FILT_BYPASS;
    repeat (6) send_frame(random_sample(), random_sample());
    filt_mode = FILT_BYPASS_ALT;
    repeat (6) send_frame(random_sample(), random_sample());
    compare_frames();
    finish_test("bypass", errors_before);
  endtask

  task automatic test_averages();
    int errors_before;
    errors_before = error_count;
    for (int m = 0; m < 4; m++) begin
      filt_mode = AVG_MODES[m];
      repeat (AVG_CLEAR) send_frame('0, '0);  // Empty history for the startup frames
      repeat (AVG_RUN) send_frame(random_sample(), random_sample());
      compare_frames();
    end
    finish_test("averages", errors_before);
  endtask

  task automatic test_weighted();
    int      errors_before;
    sample_t left;
    sample_t right;
    errors_before = error_count;
    for (int m = 0; m < 2; m++) begin
      filt_mode = (m == 0) ? FILT_WGT_HALF : FILT_WGT_UNITY;
      for (int i = 0; i < 12; i++) begin
        left  = (i % 3 == 0) ? FULL_NEG : random_sample();
        right = (i % 4 == 1) ? FULL_NEG + 24'sd1 : random_sample();
        send_frame(left, right);
      end
    end
    compare_frames();
    finish_test("weighted", errors_before);
  endtask

  task automatic test_mode_switch();
    int errors_before;
    errors_before = error_count;
    filt_mode     = FILT_AVG16;
    repeat (18) send_frame(random_sample(), random_sample());
    filt_mode = FILT_AVG2;  // History stays in the delay line
    repeat (6) send_frame(random_sample(), random_sample());
    compare_frames();
    finish_test("mode_switch", errors_before);
  endtask

  task automatic test_channels();
    int errors_before;
    errors_before = error_count;
    filt_mode     = FILT_AVG8;
    repeat (16) send_frame(FULL_NEG, random_sample());
    if (rx_q.size() > 0) begin
      check_sample("sdata_out left steady", FULL_NEG, rx_q[$].ch.left);
    end else begin
      $display("No output frame arrived during the channel test");
      error_count++;
    end
    compare_frames();
    finish_test("channels", errors_before);
  endtask

  initial begin
    clk          = 1'b0;
    reset_n      = 1'b0;
    bclk         = 1'b0;
    lrclk        = 1'b0;
    sdata_in     = 1'b0;
    filt_mode    = FILT_BYPASS;
    idle_check   = 1'b0;
    lfsr_state   = 32'ha1e683ac;
    error_count  = 0;
    tests_passed = 0;
    tests_failed = 0;
    for (int i = 0; i < `DELAY_DEPTH; i++) begin
      model_taps[0][i] = '0;
      model_taps[1][i] = '0;
    end
    repeat (16) @(negedge clk);
    reset_n = 1'b1;

    test_reset();
    test_bypass();
    test_averages();
    test_weighted();
    test_mode_switch();
    test_channels();

    send_frame('0, '0);  // Carries the last result out
    compare_frames();

    $display("Tests passed: %0d, failed: %0d, errors: %0d",
             tests_passed, tests_failed, error_count);
    if (error_count == 0 && tests_failed == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== source/audio_smoother_top.sv ====
`timescale 1ns/1ps

module audio_smoother_top (
  input  logic                  clk,
  input  logic                  reset_n,
  input  logic                  bclk,
  input  logic                  lrclk,
  input  logic                  sdata_in,
  input  audio_pkg::filt_mode_e filt_mode,
  output logic                  sdata_out
);

  import audio_pkg::*;

  stereo_frame_u rx_frame;
  stereo_frame_u tx_frame;
  logic          rx_stb;
  sample_t       left_out;
  sample_t       right_out;

  i2s_receiver i2s_receiver_inst (
    .clk       (clk),
    .reset_n   (reset_n),
    .bclk      (bclk),
    .lrclk     (lrclk),
    .sdata_in  (sdata_in),
    .frame     (rx_frame),
    .frame_stb (rx_stb)
  );

  smoothing_filter left_filter (
    .clk        (clk),
    .reset_n    (reset_n),
    .sample_stb (rx_stb),
    .mode       (filt_mode),
    .sample_in  (rx_frame.ch.left),
    .sample_out (left_out),
    .out_stb    ()
  );

  smoothing_filter right_filter (
    .clk        (clk),
    .reset_n    (reset_n),
    .sample_stb (rx_stb),
    .mode       (filt_mode),
    .sample_in  (rx_frame.ch.right),
    .sample_out (right_out),
    .out_stb    ()
  );

  assign tx_frame.ch.left  = left_out;
  assign tx_frame.ch.right = right_out;

  // Latches tx_frame at each frame start
  i2s_transmitter i2s_transmitter_inst (
    .clk     (clk),
    .reset_n (reset_n),
    .bclk    (bclk),
    .lrclk   (lrclk),
    .frame   (tx_frame),
    .sdata   (sdata_out)
  );

endmodule

// ==== source/i2s_transmitter.sv ====
`timescale 1ns/1ps
`include "audio_cfg.svh"

module i2s_transmitter (
  input  logic                     clk,
  input  logic                     reset_n,
  input  logic                     bclk,
  input  logic                     lrclk,
  input  audio_pkg::stereo_frame_u frame,
  output logic                     sdata
);

  localparam int CNT_W = $clog2(`SLOT_W) + 1;

  logic [2:0]              bclk_q;
  logic [2:0]              lrclk_q;
  logic                    bclk_fall;
  logic                    lrclk_edge;
  logic                    left_slot;
  logic [CNT_W-1:0]        bit_cnt;  // bclk periods since the lrclk edge
  logic [2*`SAMPLE_W-1:0]  shift_q;

  assign bclk_fall  = ~bclk_q[1] & bclk_q[2];
  assign lrclk_edge = lrclk_q[1] ^ lrclk_q[2];
  assign left_slot  = ~lrclk_q[1];

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      bclk_q  <= '0;
      lrclk_q <= '0;
    end else begin
      bclk_q  <= {bclk_q[1:0], bclk};
      lrclk_q <= {lrclk_q[1:0], lrclk};
    end
  end

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      bit_cnt <= '0;
      shift_q <= '0;
      sdata   <= 1'b0;
    end else if (lrclk_edge) begin
      bit_cnt <= '0;  // lrclk moves on a falling bclk, delay bit follows
    end else if (bclk_fall) begin
      if (bit_cnt != '1) bit_cnt <= bit_cnt + 1'b1;
      if (bit_cnt == '0 && left_slot) begin
        // First data bit of the frame, take the newest filter result
        sdata   <= frame.raw[2*`SAMPLE_W-1];
        shift_q <= {frame.raw[2*`SAMPLE_W-2:0], 1'b0};
      end else if (bit_cnt < CNT_W'(`SAMPLE_W)) begin
        sdata   <= shift_q[2*`SAMPLE_W-1];
        shift_q <= {shift_q[2*`SAMPLE_W-2:0], 1'b0};
      end else begin
        sdata <= 1'b0;  // Pad to end of slot
      end
    end
  end

endmodule

// ==== filter/smoothing_filter.sv ====
`timescale 1ns/1ps
`include "audio_cfg.svh"

module smoothing_filter (
  input  logic                  clk,
  input  logic                  reset_n,
  input  logic                  sample_stb,
  input  audio_pkg::filt_mode_e mode,
  input  audio_pkg::sample_t    sample_in,
  output audio_pkg::sample_t    sample_out,
  output logic                  out_stb
);

  import audio_pkg::*;

  // Headroom for a full 16-tap sum
  localparam int SUM_W  = `SAMPLE_W + $clog2(`DELAY_DEPTH);
  localparam int LOG2_W = $clog2($clog2(`DELAY_DEPTH) + 1);

  sample_t                  taps [`DELAY_DEPTH];
  logic        [LOG2_W-1:0] avg_log2;
  logic signed [SUM_W-1:0]  tap_sum;
  logic signed [SUM_W-1:0]  wgt_half;
  logic signed [SUM_W-1:0]  sum_next;
  logic signed [SUM_W-1:0]  sum_q;
  logic                     sum_stb;
  logic                     load_stb;

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      for (int i = 0; i < `DELAY_DEPTH; i++) begin
        taps[i] <= '0;
      end
    end else if (sample_stb) begin
      taps[0] <= sample_in;
      for (int i = 1; i < `DELAY_DEPTH; i++) begin
        taps[i] <= taps[i-1];
      end
    end
  end

  always_comb begin
    case (mode)
      FILT_AVG2:  avg_log2 = LOG2_W'(1);
      FILT_AVG4:  avg_log2 = LOG2_W'(2);
      FILT_AVG8:  avg_log2 = LOG2_W'(3);
      FILT_AVG16: avg_log2 = LOG2_W'(4);
      default:    avg_log2 = '0;
    endcase
  end

  // Sum of the newest 2^avg_log2 taps
  always_comb begin
    tap_sum = '0;
    for (int i = 0; i < `DELAY_DEPTH; i++) begin
      if (i < (1 << avg_log2)) tap_sum = tap_sum + SUM_W'(taps[i]);
    end
  end

  // Each tap is shifted on its own, so rounding is per tap
  assign wgt_half = SUM_W'(taps[0] >>> 4) + SUM_W'(taps[1] >>> 4)
                  + SUM_W'(taps[2] >>> 3) + SUM_W'(taps[3] >>> 2);

  always_comb begin
    case (mode)
      FILT_AVG2,
      FILT_AVG4,
      FILT_AVG8,
      FILT_AVG16:     sum_next = tap_sum >>> avg_log2;  // Floor, not round
      FILT_WGT_HALF:  sum_next = wgt_half;
      FILT_WGT_UNITY: sum_next = wgt_half + SUM_W'(taps[4] >>> 1);
      default:        sum_next = SUM_W'(taps[0]);  // Modes 0 and 7
    endcase
  end

  // Stage one waits a cycle for the shifted taps
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      sum_stb  <= 1'b0;
      load_stb <= 1'b0;
      sum_q    <= '0;
    end else begin
      sum_stb  <= sample_stb;
      load_stb <= sum_stb;
      if (sum_stb) sum_q <= sum_next;
    end
  end

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      sample_out <= '0;
      out_stb    <= 1'b0;
    end else begin
      out_stb <= load_stb;
      if (load_stb) sample_out <= sum_q[`SAMPLE_W-1:0];
    end
  end

endmodule

// ==== source/i2s_receiver.sv ====
`timescale 1ns/1ps
`include "audio_cfg.svh"

module i2s_receiver (
  input  logic                     clk,
  input  logic                     reset_n,
  input  logic                     bclk,
  input  logic                     lrclk,
  input  logic                     sdata_in,
  output audio_pkg::stereo_frame_u frame,
  output logic                     frame_stb
);

  import audio_pkg::*;

  localparam int CNT_W = $clog2(`SLOT_W) + 1;

  logic [2:0]       bclk_q;   // Two sync stages plus one of history
  logic [2:0]       lrclk_q;
  logic [1:0]       sdata_q;  // Same depth as bclk so they stay aligned
  logic             bclk_rise;
  logic             lrclk_edge;
  logic             lrclk_fall;
  logic [CNT_W-1:0] bit_cnt;
  stereo_frame_u    shift_q;

  assign bclk_rise  = bclk_q[1] & ~bclk_q[2];
  assign lrclk_edge = lrclk_q[1] ^ lrclk_q[2];
  assign lrclk_fall = ~lrclk_q[1] & lrclk_q[2];  // End of right slot

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      bclk_q  <= '0;
      lrclk_q <= '0;
      sdata_q <= '0;
    end else begin
      bclk_q  <= {bclk_q[1:0], bclk};
      lrclk_q <= {lrclk_q[1:0], lrclk};
      sdata_q <= {sdata_q[0], sdata_in};
    end
  end

  // Bit position within the current slot, period 0 is the I2S delay bit
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      bit_cnt <= '0;
    end else if (lrclk_edge) begin
      bit_cnt <= '0;
    end else if (bclk_rise && bit_cnt != '1) begin
      bit_cnt <= bit_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (bclk_rise && !lrclk_edge && bit_cnt >= CNT_W'(1)
        && bit_cnt <= CNT_W'(`SAMPLE_W)) begin
      shift_q.raw <= {shift_q.raw[2*`SAMPLE_W-2:0], sdata_q[1]};
    end
  end

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      frame     <= '0;
      frame_stb <= 1'b0;
    end else begin
      frame_stb <= lrclk_fall;
      if (lrclk_fall) frame <= shift_q;
    end
  end

endmodule

// ==== common/audio_pkg.sv ====
`include "audio_cfg.svh"

package audio_pkg;

  typedef logic signed [`SAMPLE_W-1:0] sample_t;

  typedef enum logic [2:0] {
    FILT_BYPASS      = 3'd0,
    FILT_AVG2        = 3'd1,
    FILT_AVG4        = 3'd2,
    FILT_AVG8        = 3'd3,
    FILT_AVG16       = 3'd4,
    FILT_WGT_HALF    = 3'd5,  // 1/16 1/16 1/8 1/4
    FILT_WGT_UNITY   = 3'd6,  // 1/16 1/16 1/8 1/4 1/2
    FILT_BYPASS_ALT  = 3'd7
  } filt_mode_e;

  // Serial image and per-channel view of one stereo frame
  typedef union packed {
    logic [2*`SAMPLE_W-1:0] raw;  // Left MSB first, then right
    struct packed {
      sample_t left;
      sample_t right;
    } ch;
  } stereo_frame_u;

endpackage

// ==== common/audio_cfg.svh ====
`ifndef AUDIO_CFG_SVH
`define AUDIO_CFG_SVH

// Width of one audio sample
`define SAMPLE_W 24

// Taps in the smoothing delay line
`define DELAY_DEPTH 16

// bclk periods per channel slot
`define SLOT_W 32

`endif
